// File: Makefile
# Verilator build and run for the ARM execute core

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tbArmExec -f all.f

run: compile
	./obj_dir/VtbArmExec | tee sim.log
	@if grep -q "=== FAIL ===" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "=== PASS ===" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: all.f
+incdir+verilog
verilog/corePkg.sv
verilog/instrQueue.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/shiftUnit.sv
verilog/aluFlags.sv
verilog/creditCounter.sv
verilog/execSequencer.sv
verilog/armExecCore.sv
testbench/tbArmExec.sv

// File: testbench/tbArmExec.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute core testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "coreParams.svh"

module tbArmExec;

    localparam int NumInstr      = 200;
    localparam int TimeoutCycles = NumInstr * 20;

    logic                   Clk;
    logic                   Reset;
    logic                   instrValid;
    logic [`DATA_W-1:0]     instr;
    logic                   resCredit;
    logic                   instrCredit;
    logic                   resValid;
    logic [`REG_ADDR_W-1:0] resRd;
    logic [`DATA_W-1:0]     resData;
    logic [3:0]             resFlags;

    logic [`DATA_W-1:0]     modelRegs [16];
    logic [3:0]             modelFlags;            // N Z C V
    logic [`REG_ADDR_W-1:0] expRd    [NumInstr];   // Expected results in issue order
    logic [`DATA_W-1:0]     expData  [NumInstr];
    logic [3:0]             expFlags [NumInstr];
    logic [`REG_ADDR_W-1:0] expRdNow;
    logic [`DATA_W-1:0]     expDataNow;
    logic [3:0]             expFlagsLast;

    int expCount        = 0;
    int sentCount       = 0;
    int droppedCount    = 0;
    int resCount        = 0;
    int creditsBack     = 0;   // instrCredit pulses seen
    int creditsReturned = 0;   // resCredit pulses sent
    int stallLeft       = 0;
    int cycleCount      = 0;
    int errorCount      = 0;

    armExecCore dut_i (.Clk(Clk), .Reset(Reset), .instrValid(instrValid), .instr(instr),
        .resCredit(resCredit), .instrCredit(instrCredit), .resValid(resValid),
        .resRd(resRd), .resData(resData), .resFlags(resFlags));

    initial Clk = 1'b0;
    always #10 Clk = ~Clk;

    assign expRdNow     = expRd[resCount];
    assign expDataNow   = expData[resCount];
    assign expFlagsLast = expFlags[resCount - 1];   // Flags settle one cycle after resValid

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errorCount++;
        $display("ERROR %s expected %h actual %h", name, expected, actual);
    endtask

    task automatic reportFailure(input string text);
        errorCount++;
        $display("%s", text);
    endtask

    task automatic printSummary();
        $display("Errors %0d, results %0d of %0d, dropped words %0d, cycles %0d",
                 errorCount, resCount, expCount, droppedCount, cycleCount);
    endtask

    function automatic logic [31:0] rotateRight(input logic [31:0] value, input int amount);
        logic [31:0] v;
        v = value;
        for (int i = 0; i < amount; i++)
            v = {v[0], v[31:1]};
        return v;
    endfunction

    // Second operand from the immediate rotate or the shifted Rm
    function automatic logic [31:0] modelOperand2(input logic [31:0] word);
        logic [31:0] rmVal;
        int          amount;
        rmVal  = modelRegs[word[3:0]];
        amount = int'(word[11:7]);
        if (word[25])
            return rotateRight({24'd0, word[7:0]}, 2 * int'(word[11:8]));
        if (amount == 0)
            return rmVal;
        case (word[6:5])
            2'd0:    return rmVal << amount;
            2'd1:    return rmVal >> amount;
            2'd2:    return $signed(rmVal) >>> amount;
            default: return rotateRight(rmVal, amount);
        endcase
    endfunction

    // Signed and unsigned results in 64 bits give C and V directly
    task automatic arith(input logic [31:0] x, input logic [31:0] y, input logic subtract,
                         input logic cin, output logic [31:0] r, output logic c,
                         output logic v);
        longint u;
        longint s;
        longint carry;
        carry = cin ? 1 : 0;
        if (subtract) begin
            u = longint'(x) - longint'(y) - (1 - carry);
            s = longint'($signed(x)) - longint'($signed(y)) - (1 - carry);
            c = (u >= 0);                              // No borrow
        end else begin
            u = longint'(x) + longint'(y) + carry;
            s = longint'($signed(x)) + longint'($signed(y)) + carry;
            c = u[32];
        end
        r = u[31:0];
        v = (s > 64'sd2147483647) || (s < -64'sd2147483648);
    endtask

    task automatic applyInstr(input logic [31:0] word);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic        c;
        logic        v;
        a = modelRegs[word[19:16]];
        b = modelOperand2(word);
        r = '0;
        c = modelFlags[1];   // Logical opcodes keep C and V
        v = modelFlags[0];
        case (corePkg::aluOp'(word[24:21]))
            corePkg::And, corePkg::Tst: r = a & b;
            corePkg::Eor, corePkg::Teq: r = a ^ b;
            corePkg::Orr:               r = a | b;
            corePkg::Mov:               r = b;
            corePkg::Bic:               r = a & ~b;
            corePkg::Mvn:               r = ~b;
            corePkg::Sub, corePkg::Cmp: arith(a, b, 1'b1, 1'b1, r, c, v);
            corePkg::Rsb:               arith(b, a, 1'b1, 1'b1, r, c, v);
            corePkg::Add, corePkg::Cmn: arith(a, b, 1'b0, 1'b0, r, c, v);
            corePkg::Adc:               arith(a, b, 1'b0, modelFlags[1], r, c, v);
            corePkg::Sbc:               arith(a, b, 1'b1, modelFlags[1], r, c, v);
            default:                    arith(b, a, 1'b1, modelFlags[1], r, c, v);   // RSC
        endcase
        if (word[20])
            modelFlags = {r[31], r == 32'd0, c, v};
        if (word[24:23] != 2'b10)
            modelRegs[word[15:12]] = r;   // Test opcodes leave Rd alone
        expRd[expCount]    = word[15:12];
        expData[expCount]  = r;
        expFlags[expCount] = modelFlags;
        expCount++;
    endtask

    function automatic logic [31:0] supportedWord();
        logic [3:0]  op;
        logic        s;
        logic        imm;
        logic [11:0] operand;
        op  = 4'($urandom_range(15, 0));
        s   = (op[3:2] == 2'b10) ? 1'b1 : 1'($urandom_range(1, 0));
        imm = 1'($urandom_range(1, 0));
        if (imm) begin
            operand = 12'($urandom);
        end else begin
            operand = {5'($urandom), 2'($urandom), 1'b0, 4'($urandom)};
            if ($urandom_range(3, 0) == 0)
                operand[11:7] = 5'd0;          // Pass-through shift
        end
        return {4'hE, 2'b00, imm, op, s, 4'($urandom), 4'($urandom), operand};
    endfunction

    function automatic logic [31:0] unsupportedWord();
        logic [31:0] word;
        word = $urandom;
        if ($urandom_range(1, 0) == 1) begin
            word[27:26] = 2'($urandom_range(3, 1));   // Not data processing
        end else begin
            word[27:25] = 3'b000;                     // Register-specified shift
            word[7]     = 1'b0;
            word[4]     = 1'b1;
        end
        return word;
    endfunction

    // Producer, model and end of run
    initial begin
        logic [31:0] word;
        logic        isSupported;
        int          followRm;
        void'($urandom(59401));
        Reset      = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        resCredit  = 1'b0;
        modelFlags = 4'b0000;
        followRm   = -1;
        for (int i = 0; i < 16; i++)
            modelRegs[i] = '0;
        repeat (3) @(posedge Clk);
        @(negedge Clk);
        Reset = 1'b0;
        while (sentCount < NumInstr) begin
            @(negedge Clk);
            instrValid = 1'b0;
            if (sentCount - creditsBack < `QUEUE_DEPTH && $urandom_range(5, 0) != 0) begin
                isSupported = 1'b1;
                if (followRm >= 0) begin
                    // MOV from the register a test opcode named as Rd
                    word = {4'hE, 3'b000, corePkg::Mov, 1'b0, 4'h0, 4'($urandom), 8'h00,
                            4'(followRm)};
                    followRm = -1;
                end else if ($urandom_range(11, 0) == 0) begin
                    word        = unsupportedWord();
                    isSupported = 1'b0;
                end else begin
                    word = supportedWord();
                end
                instr      = word;
                instrValid = 1'b1;
                sentCount++;
                if (isSupported) begin
                    if (word[24:23] == 2'b10)
                        followRm = int'(word[15:12]);
                    applyInstr(word);
                end else begin
                    droppedCount++;
                end
            end
        end
        @(negedge Clk);
        instrValid = 1'b0;
        wait (resCount == expCount && creditsBack == sentCount);
        repeat (4) @(posedge Clk);
        assert (resCount == expCount)
            else reportFailure("Extra result arrived after the program ended");
        printSummary();
        if (errorCount == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // Consumer returns credits with random stalls
    always @(negedge Clk) begin
        resCredit = 1'b0;
        if (!Reset) begin
            if (stallLeft > 0) begin
                stallLeft--;
            end else if ($urandom_range(9, 0) == 0) begin
                stallLeft = $urandom_range(20, 1);
            end else if (resCount - creditsReturned > 0) begin
                resCredit = 1'b1;
                creditsReturned++;
            end
        end
    end

    always @(posedge Clk) begin
        if (!Reset) begin
            if (resValid)
                resCount <= resCount + 1;
            if (instrCredit)
                creditsBack <= creditsBack + 1;
            cycleCount <= cycleCount + 1;
            if (cycleCount >= TimeoutCycles) begin
                $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
                printSummary();
                $display("=== FAIL ===");
                $finish;
            end
        end
    end

    assert property (@(posedge Clk) disable iff (Reset)
        sentCount == 0 |-> !resValid && !instrCredit)
        else reportFailure("resValid or instrCredit went high before any instruction");

    assert property (@(posedge Clk) disable iff (Reset) resValid |-> resCount < expCount)
        else reportFailure("Result arrived with no supported instruction outstanding");

    assert property (@(posedge Clk) disable iff (Reset) resValid |-> resRd == expRdNow)
        else reportMismatch("resRd", $sampled(expRdNow), $sampled(resRd));

    assert property (@(posedge Clk) disable iff (Reset) resValid |-> resData == expDataNow)
        else reportMismatch("resData", $sampled(expDataNow), $sampled(resData));

    assert property (@(posedge Clk) disable iff (Reset) resValid |=> resFlags == expFlagsLast)
        else reportMismatch("resFlags", $sampled(expFlagsLast), $sampled(resFlags));

    assert property (@(posedge Clk) disable iff (Reset)
        resValid |-> resCount - creditsReturned < `RESULT_CREDITS)
        else reportFailure("Result sent while the consumer held no free credit");

    assert property (@(posedge Clk) disable iff (Reset) instrCredit |-> sentCount > creditsBack)
        else reportFailure("instrCredit returned with no instruction outstanding");

endmodule

// File: verilog/aluFlags.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU and NZCV flags
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "coreParams.svh"

module aluFlags (
    input  logic               Clk,
    input  logic               Reset,
    input  corePkg::aluOp      op,
    input  logic [`DATA_W-1:0] operandA,
    input  logic [`DATA_W-1:0] operand2,
    input  logic               flagUpdate,
    output logic [`DATA_W-1:0] result,
    output logic [3:0]         flags       // N Z C V
);

    logic [`DATA_W-1:0] addX;
    logic [`DATA_W-1:0] addY;
    logic               addCin;
    logic [`DATA_W:0]   sum;
    logic [`DATA_W-1:0] logicRes;
    logic               isArith;
    logic               overflow;
    logic [3:0]         nextFlags;

    // One adder serves every arithmetic opcode; subtraction adds the
    // inverted operand with a carry in, so carry out means no borrow
    always_comb begin
        addX     = operandA;
        addY     = operand2;
        addCin   = 1'b0;
        isArith  = 1'b1;
        logicRes = '0;
        case (op)
            corePkg::Sub, corePkg::Cmp: begin
                addY   = ~operand2;
                addCin = 1'b1;
            end
            corePkg::Rsb: begin
                addX   = operand2;
                addY   = ~operandA;
                addCin = 1'b1;
            end
            corePkg::Adc: addCin = flags[1];
            corePkg::Sbc: begin
                addY   = ~operand2;
                addCin = flags[1];
            end
            corePkg::Rsc: begin
                addX   = operand2;
                addY   = ~operandA;
                addCin = flags[1];
            end
            corePkg::Add, corePkg::Cmn: addCin = 1'b0;
            corePkg::And, corePkg::Tst: begin
                isArith  = 1'b0;
                logicRes = operandA & operand2;
            end
            corePkg::Eor, corePkg::Teq: begin
                isArith  = 1'b0;
                logicRes = operandA ^ operand2;
            end
            corePkg::Orr: begin
                isArith  = 1'b0;
                logicRes = operandA | operand2;
            end
            corePkg::Mov: begin
                isArith  = 1'b0;
                logicRes = operand2;
            end
            corePkg::Bic: begin
                isArith  = 1'b0;
                logicRes = operandA & ~operand2;
            end
            default: begin                        // MVN
                isArith  = 1'b0;
                logicRes = ~operand2;
            end
        endcase
    end

    assign sum      = {1'b0, addX} + {1'b0, addY} + {{`DATA_W{1'b0}}, addCin};
    assign result   = isArith ? sum[`DATA_W-1:0] : logicRes;
    assign overflow = (addX[`DATA_W-1] == addY[`DATA_W-1]) &&
                      (sum[`DATA_W-1] != addX[`DATA_W-1]);

    // Logical opcodes keep C and V
    assign nextFlags = {result[`DATA_W-1], result == '0,
                        isArith ? sum[`DATA_W] : flags[1],
                        isArith ? overflow : flags[0]};

    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset)
            flags <= 4'b0000;
        else if (flagUpdate)
            flags <= nextFlags;
    end

    assert property (@(posedge Clk) disable iff (Reset) !$isunknown(flags))
        else $error("aluFlags flags unknown after reset");

endmodule

// File: verilog/armExecCore.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ARM execute core top
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "coreParams.svh"

module armExecCore (
    input  logic                   Clk,
    input  logic                   Reset,
    input  logic                   instrValid,
    input  logic [`DATA_W-1:0]     instr,
    input  logic                   resCredit,
    output logic                   instrCredit,
    output logic                   resValid,
    output logic [`REG_ADDR_W-1:0] resRd,
    output logic [`DATA_W-1:0]     resData,
    output logic [3:0]             resFlags
);

    logic [`DATA_W-1:0]     head;
    logic                   queueEmpty;
    logic                   pop;
    corePkg::aluOp          op;
    logic                   sBit;
    logic                   immForm;
    logic [`REG_ADDR_W-1:0] rn;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rm;
    logic [3:0]             rotate;
    logic [7:0]             imm8;
    logic [4:0]             shiftAmount;
    corePkg::shiftKind      shiftType;
    logic                   supported;
    logic                   writesRd;
    logic [`DATA_W-1:0]     rnData;
    logic [`DATA_W-1:0]     rmData;
    logic [`DATA_W-1:0]     operand2;
    logic                   latchOperands;
    logic                   regWrite;
    logic                   flagUpdate;
    logic                   hasCredit;
    logic [`DATA_W-1:0]     aluResult;

    // Operands and fields held for the Execute cycle
    corePkg::aluOp          opLatched;
    logic [`REG_ADDR_W-1:0] rdLatched;
    logic [`DATA_W-1:0]     operandALatched;
    logic [`DATA_W-1:0]     operand2Latched;

    always_ff @(posedge Clk) begin
        if (latchOperands) begin
            opLatched       <= op;
            rdLatched       <= rd;
            operandALatched <= rnData;
            operand2Latched <= operand2;
        end
    end

    instrQueue queueInst (.Clk(Clk), .Reset(Reset), .instrValid(instrValid), .instr(instr),
        .pop(pop), .head(head), .queueEmpty(queueEmpty));

    instrDecoder decoderInst (.instr(head), .op(op), .sBit(sBit), .immForm(immForm),
        .rn(rn), .rd(rd), .rm(rm), .rotate(rotate), .imm8(imm8), .shiftAmount(shiftAmount),
        .shiftType(shiftType), .supported(supported), .writesRd(writesRd));

    regFile regFileInst (.Clk(Clk), .Reset(Reset), .rn(rn), .rm(rm), .writeEn(regWrite),
        .writeAddr(rdLatched), .writeData(aluResult), .rnData(rnData), .rmData(rmData));

    shiftUnit shifterInst (.immForm(immForm), .rotate(rotate), .imm8(imm8),
        .rmData(rmData), .shiftType(shiftType), .shiftAmount(shiftAmount),
        .operand2(operand2));

    aluFlags aluInst (.Clk(Clk), .Reset(Reset), .op(opLatched), .operandA(operandALatched),
        .operand2(operand2Latched), .flagUpdate(flagUpdate), .result(aluResult),
        .flags(resFlags));

    creditCounter creditInst (.Clk(Clk), .Reset(Reset), .consume(resValid),
        .creditReturn(resCredit), .hasCredit(hasCredit));

    execSequencer seqInst (.Clk(Clk), .Reset(Reset), .queueEmpty(queueEmpty),
        .supported(supported), .writesRd(writesRd), .sBit(sBit), .hasCredit(hasCredit),
        .latchOperands(latchOperands), .regWrite(regWrite), .flagUpdate(flagUpdate),
        .resValid(resValid), .pop(pop), .instrCredit(instrCredit));

    assign resRd   = rdLatched;
    assign resData = aluResult;   // Test opcodes report the unwritten value

endmodule

// File: verilog/coreParams.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute core parameters
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Register and operand width
`define DATA_W 32

// Register index width, 16 registers
`define REG_ADDR_W 4

// Queue entries, also the producer's starting credits
`define QUEUE_DEPTH 2

// Result credits held by the core after reset
`define RESULT_CREDITS 4

`endif

// File: verilog/corePkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute core types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package corePkg;

    typedef enum logic [1:0] {
        Idle,                      // Waiting for the queue
        Read,                      // Operand fetch and latch
        Execute                    // ALU, writeback, result
    } seqState;

    // Encoded as instruction bits 24..21
    typedef enum logic [3:0] {
        And, Eor, Sub, Rsb,
        Add, Adc, Sbc, Rsc,
        Tst, Teq, Cmp, Cmn,
        Orr, Mov, Bic, Mvn
    } aluOp;

    // Encoded as instruction bits 6..5
    typedef enum logic [1:0] {
        Lsl,
        Lsr,
        Asr,
        Ror
    } shiftKind;

endpackage

// File: verilog/creditCounter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result credit counter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "coreParams.svh"

module creditCounter (
    input  logic Clk,
    input  logic Reset,
    input  logic consume,
    input  logic creditReturn,
    output logic hasCredit
);

    localparam int CountW = $clog2(`RESULT_CREDITS + 1);

    logic [CountW-1:0] count;

    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset)
            count <= CountW'(`RESULT_CREDITS);   // Full after reset
        else
            count <= count + CountW'(creditReturn) - CountW'(consume);
    end

    assign hasCredit = (count != '0);

    // Consumer never over-returns and the core never overspends
    assert property (@(posedge Clk) disable iff (Reset)
        !(creditReturn && !consume && count == CountW'(`RESULT_CREDITS)))
        else $error("creditCounter count above RESULT_CREDITS");

    assert property (@(posedge Clk) disable iff (Reset)
        !(consume && !creditReturn && count == '0))
        else $error("creditCounter count below zero");

endmodule

// File: verilog/execSequencer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute sequencer FSM
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module execSequencer (
    input  logic Clk,
    input  logic Reset,
    input  logic queueEmpty,
    input  logic supported,
    input  logic writesRd,
    input  logic sBit,
    input  logic hasCredit,
    output logic latchOperands,
    output logic regWrite,
    output logic flagUpdate,
    output logic resValid,
    output logic pop,
    output logic instrCredit
);

    corePkg::seqState state;
    corePkg::seqState nextState;

    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset)
            state <= corePkg::Idle;
        else
            state <= nextState;
    end

    // Head stays put until the pop, so decoder outputs hold through Execute
    always_comb begin
        nextState     = state;
        latchOperands = 1'b0;
        regWrite      = 1'b0;
        flagUpdate    = 1'b0;
        resValid      = 1'b0;
        pop           = 1'b0;
        case (state)
            corePkg::Idle: begin
                if (!queueEmpty)
                    nextState = corePkg::Read;
            end
            corePkg::Read: begin
                if (supported) begin
                    latchOperands = 1'b1;
                    nextState     = corePkg::Execute;
                end else begin
                    pop       = 1'b1;                 // Drop unsupported word
                    nextState = corePkg::Idle;
                end
            end
            corePkg::Execute: begin
                if (hasCredit) begin                  // Else stall, queue intact
                    regWrite   = writesRd;
                    flagUpdate = sBit;
                    resValid   = 1'b1;
                    pop        = 1'b1;
                    nextState  = corePkg::Idle;
                end
            end
            default: nextState = corePkg::Idle;
        endcase
    end

    assign instrCredit = pop;   // Every retire frees one queue entry

    // A result spends a credit and retires a queued word
    assert property (@(posedge Clk) disable iff (Reset)
        resValid |-> hasCredit && !queueEmpty)
        else $error("execSequencer result without credit or queued instruction");

endmodule

// File: verilog/instrDecoder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data-processing decoder
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "coreParams.svh"

module instrDecoder (
    input  logic [`DATA_W-1:0]    instr,
    output corePkg::aluOp         op,
    output logic                  sBit,
    output logic                  immForm,
    output logic [`REG_ADDR_W-1:0] rn,
    output logic [`REG_ADDR_W-1:0] rd,
    output logic [`REG_ADDR_W-1:0] rm,
    output logic [3:0]            rotate,
    output logic [7:0]            imm8,
    output logic [4:0]            shiftAmount,
    output corePkg::shiftKind     shiftType,
    output logic                  supported,
    output logic                  writesRd
);

    // Register fields
    assign rn = instr[19:16];
    assign rd = instr[15:12];
    assign rm = instr[3:0];

    assign op      = corePkg::aluOp'(instr[24:21]);
    assign sBit    = instr[20];
    assign immForm = instr[25];

    // Immediate operand form
    assign rotate = instr[11:8];
    assign imm8   = instr[7:0];

    // Register operand form, shift by immediate only
    assign shiftAmount = instr[11:7];
    assign shiftType   = corePkg::shiftKind'(instr[6:5]);

    // Data-processing class only. Bit 4 set with a register operand
    // selects a register-specified shift, which this core lacks
    assign supported = (instr[27:26] == 2'b00) && (instr[25] || !instr[4]);

    // Test opcodes only set flags
    assign writesRd = !(op inside {corePkg::Tst, corePkg::Teq,
                                   corePkg::Cmp, corePkg::Cmn});

endmodule

// File: verilog/instrQueue.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction queue
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "coreParams.svh"

module instrQueue (
    input  logic               Clk,
    input  logic               Reset,
    input  logic               instrValid,
    input  logic [`DATA_W-1:0] instr,
    input  logic               pop,
    output logic [`DATA_W-1:0] head,
    output logic               queueEmpty
);

    localparam int PtrW   = $clog2(`QUEUE_DEPTH);
    localparam int CountW = $clog2(`QUEUE_DEPTH + 1);

    logic [`DATA_W-1:0] entries [`QUEUE_DEPTH];
    logic [PtrW-1:0]    wrPtr;
    logic [PtrW-1:0]    rdPtr;
    logic [CountW-1:0]  count;

    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (instrValid)
                wrPtr <= (wrPtr == PtrW'(`QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (pop)
                rdPtr <= (rdPtr == PtrW'(`QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            case ({instrValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (instrValid)
            entries[wrPtr] <= instr;
    end

    assign head       = entries[rdPtr];
    assign queueEmpty = (count == '0);

    // The producer's credits keep writes off a full queue
    assert property (@(posedge Clk) disable iff (Reset)
        instrValid |-> count != CountW'(`QUEUE_DEPTH))
        else $error("instrQueue write while full");

    assert property (@(posedge Clk) disable iff (Reset) pop |-> !queueEmpty)
        else $error("instrQueue pop while empty");

endmodule

// File: verilog/regFile.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "coreParams.svh"

module regFile (
    input  logic                   Clk,
    input  logic                   Reset,
    input  logic [`REG_ADDR_W-1:0] rn,
    input  logic [`REG_ADDR_W-1:0] rm,
    input  logic                   writeEn,
    input  logic [`REG_ADDR_W-1:0] writeAddr,
    input  logic [`DATA_W-1:0]     writeData,
    output logic [`DATA_W-1:0]     rnData,
    output logic [`DATA_W-1:0]     rmData
);

    logic [`DATA_W-1:0] regs [2**`REG_ADDR_W];   // R15 is a plain register

    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < 2**`REG_ADDR_W; i++)
                regs[i] <= '0;
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Combinational read ports
    assign rnData = regs[rn];
    assign rmData = regs[rm];

endmodule

// File: verilog/shiftUnit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand 2 shifter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "coreParams.svh"

module shiftUnit (
    input  logic               immForm,
    input  logic [3:0]         rotate,
    input  logic [7:0]         imm8,
    input  logic [`DATA_W-1:0] rmData,
    input  corePkg::shiftKind  shiftType,
    input  logic [4:0]         shiftAmount,
    output logic [`DATA_W-1:0] operand2
);

    logic [`DATA_W-1:0]   immExt;
    logic [2*`DATA_W-1:0] immRot;
    logic [2*`DATA_W-1:0] regRot;
    logic [`DATA_W-1:0]   regShifted;

    assign immExt = {{(`DATA_W-8){1'b0}}, imm8};
    assign immRot = {immExt, immExt} >> {rotate, 1'b0};   // Rotate by twice the field
    assign regRot = {rmData, rmData} >> shiftAmount;

    always_comb begin
        if (shiftAmount == 5'd0) begin
            regShifted = rmData;                  // Zero amount passes through
        end else begin
            case (shiftType)
                corePkg::Lsl: regShifted = rmData << shiftAmount;
                corePkg::Lsr: regShifted = rmData >> shiftAmount;
                corePkg::Asr: regShifted = $signed(rmData) >>> shiftAmount;
                default:      regShifted = regRot[`DATA_W-1:0];   // ROR
            endcase
        end
    end

    assign operand2 = immForm ? immRot[`DATA_W-1:0] : regShifted;

endmodule
